//--- list.f
frontend_pkg.sv
fetch_block_gen.sv
ftq.sv
ifu.sv
frontend.sv
frontend_properties.sv
tb_frontend.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - frontend_pkg.sv
  - fetch_block_gen.sv
  - ftq.sv
  - ifu.sv
  - frontend.sv
  - target: test
    files:
      - frontend_properties.sv
      - tb_frontend.sv

//--- tb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frontend
    import frontend_pkg::*;
();

    localparam int                    DEPTH        = 4;
    localparam logic [ADDR_WIDTH-1:0] START_PC     = 32'h1c000ff4;
    localparam logic [ADDR_WIDTH-1:0] FLUSH_PC_A   = 32'h1c002ff8;
    localparam logic [ADDR_WIDTH-1:0] FLUSH_PC_B   = 32'h1c00401c;
    localparam int                    RESET_CYCLES = 3;
    localparam int                    BLOCKS_SEQ   = 24;
    localparam int                    BLOCKS_MID   = 12;
    localparam int                    BLOCKS_TAIL  = 24;
    localparam int                    HOLD_WINDOW  = 60;
    localparam int                    TOTAL_BLOCKS = BLOCKS_SEQ + DEPTH + BLOCKS_MID + BLOCKS_TAIL;
    localparam int                    TIMEOUT_CYCLES = 40 * TOTAL_BLOCKS + HOLD_WINDOW + RESET_CYCLES;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    backend_flush_i;
    logic [ADDR_WIDTH-1:0]                   backend_next_pc_i;
    logic                                    backend_commit_i;
    logic                                    instr_buffer_stall_i;
    logic [FETCH_WIDTH-1:0]                  instr_valid_o;
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] instr_o;
    logic [ADDR_WIDTH-1:0]                   fetch_pc_o;
    logic                                    wb_cyc_o;
    logic                                    wb_stb_o;
    logic                                    wb_we_o;
    logic [ADDR_WIDTH-1:0]                   wb_adr_o;
    logic [LINE_WIDTH-1:0]                   wb_dat_i;
    logic                                    wb_ack_i;

    integer                seed = 32'h660f483a;
    logic                  commit_en;
    logic                  mem_busy;
    logic [1:0]            ack_wait;
    logic [ADDR_WIDTH-1:0] exp_pc;
    int                    blocks_seen = 0;
    int                    cycle_cnt = 0;

    frontend #(
        .FTQ_DEPTH(DEPTH),
        .RESET_PC (START_PC)
    ) u_frontend (
        .clk                 (clk),
        .rst_n               (rst_n),
        .backend_flush_i     (backend_flush_i),
        .backend_next_pc_i   (backend_next_pc_i),
        .backend_commit_i    (backend_commit_i),
        .instr_buffer_stall_i(instr_buffer_stall_i),
        .instr_valid_o       (instr_valid_o),
        .instr_o             (instr_o),
        .fetch_pc_o          (fetch_pc_o),
        .wb_cyc_o            (wb_cyc_o),
        .wb_stb_o            (wb_stb_o),
        .wb_we_o             (wb_we_o),
        .wb_adr_o            (wb_adr_o),
        .wb_dat_i            (wb_dat_i),
        .wb_ack_i            (wb_ack_i)
    );

    // Expected instruction word stored at a word address
    function automatic logic [INSTR_WIDTH-1:0] ref_word(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[13:2], addr[31:14], 2'b11} ^ 32'h9e3779b9;
    endfunction

    // Four words, or fewer so the block ends on the page boundary
    function automatic logic [BLOCK_LEN_WIDTH-1:0] ref_length(input logic [ADDR_WIDTH-1:0] pc);
        int words_left;
        words_left = ((1 << PAGE_OFFSET_W) - int'(pc[PAGE_OFFSET_W-1:0])) / 4;
        return (words_left < FETCH_WIDTH) ? BLOCK_LEN_WIDTH'(words_left)
                                          : BLOCK_LEN_WIDTH'(FETCH_WIDTH);
    endfunction

    function automatic logic [LINE_WIDTH-1:0] line_at(input logic [ADDR_WIDTH-1:0] adr);
        cache_line_u line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line.raw[i*INSTR_WIDTH +: INSTR_WIDTH] = ref_word(adr + ADDR_WIDTH'(4 * i));
        end
        return line.raw;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] got,
                              input logic [ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [INSTR_WIDTH-1:0] got,
                              input logic [INSTR_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input logic [FETCH_WIDTH-1:0] got,
                              input logic [FETCH_WIDTH-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic wait_blocks(input int count);
        int target;
        target = blocks_seen + count;
        while (blocks_seen < target) begin
            @(posedge clk);
        end
    endtask

    // Redirect while a line read is still open, so its data must be dropped
    task automatic flush_during_read(input logic [ADDR_WIDTH-1:0] target, input logic hold);
        do begin
            @(posedge clk);
        end while (!(wb_cyc_o && !wb_ack_i));
        backend_flush_i   <= 1'b1;
        backend_next_pc_i <= target;
        if (hold) begin
            commit_en <= 1'b0;
        end
        @(posedge clk);
        backend_flush_i <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timed out after %0d cycles with %0d blocks delivered",
                               cycle_cnt, blocks_seen));
        end
    end

    // Wishbone slave, one beat per cycle after a random wait
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_i <= 1'b0;
            mem_busy <= 1'b0;
            ack_wait <= '0;
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
            mem_busy <= 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!mem_busy) begin
                mem_busy <= 1'b1;
                ack_wait <= 2'($random(seed));
            end else if (ack_wait == '0) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= line_at(wb_adr_o);
            end else begin
                ack_wait <= ack_wait - 1'b1;
            end
        end
    end

    // Random back-pressure and commits
    always @(posedge clk) begin
        if (rst_n) begin
            instr_buffer_stall_i <= (($random(seed) & 3) == 0);
            backend_commit_i     <= commit_en && (($random(seed) & 1) == 1);
        end
    end

    // Outputs are compared mid-cycle where they are settled
    always @(negedge clk) begin
        logic [BLOCK_LEN_WIDTH-1:0] len;
        if (!rst_n) begin
            exp_pc = START_PC;
            if (wb_cyc_o || wb_stb_o || (instr_valid_o != '0)) begin
                fail_run("Output valid or bus cycle active while reset is asserted");
            end
        end else begin
            if (instr_buffer_stall_i) begin
                check_mask("instr_valid_o", instr_valid_o, '0);
            end else if (instr_valid_o != '0) begin
                len = ref_length(exp_pc);
                check_addr("fetch_pc_o", fetch_pc_o, exp_pc);
                check_mask("instr_valid_o", instr_valid_o, FETCH_WIDTH'((1 << len) - 1));
                for (int i = 0; i < len; i++) begin
                    check_word($sformatf("instr_o[%0d]", i), instr_o[i],
                               ref_word(exp_pc + ADDR_WIDTH'(4 * i)));
                end
                exp_pc      = exp_pc + ADDR_WIDTH'({len, 2'b00});
                blocks_seen = blocks_seen + 1;
            end
            // A block seen in the flush cycle still belongs to the old path
            if (backend_flush_i) begin
                exp_pc = backend_next_pc_i;
            end
        end
    end

    initial begin
        int hold_start;
        rst_n                = 1'b0;
        backend_flush_i      = 1'b0;
        backend_next_pc_i    = '0;
        backend_commit_i     = 1'b0;
        instr_buffer_stall_i = 1'b0;
        wb_dat_i             = '0;
        wb_ack_i             = 1'b0;
        commit_en            = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        wait_blocks(BLOCKS_SEQ);

        // Queue starts empty, so only DEPTH blocks may come out without commits
        flush_during_read(FLUSH_PC_A, 1'b1);
        hold_start = blocks_seen;
        wait_blocks(DEPTH);
        repeat (HOLD_WINDOW) @(posedge clk);
        if (blocks_seen != hold_start + DEPTH) begin
            fail_run($sformatf("Delivered %0d blocks while commits were withheld, limit is %0d",
                               blocks_seen - hold_start, DEPTH));
        end
        commit_en <= 1'b1;
        wait_blocks(BLOCKS_MID);

        flush_during_read(FLUSH_PC_B, 1'b0);
        wait_blocks(BLOCKS_TAIL);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- frontend_properties.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_properties
    import frontend_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc_o,
    input  logic                   wb_stb_o,
    input  logic                   wb_we_o,
    input  logic [ADDR_WIDTH-1:0]  wb_adr_o,
    input  logic                   wb_ack_i,
    input  logic [FETCH_WIDTH-1:0] instr_valid_o
);

    // Strobe only inside an open bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_o |-> wb_cyc_o)
        else $error("wb_stb_o high without wb_cyc_o");

    // Request held with a stable address until the slave acks
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc_o && wb_stb_o && !wb_ack_i) |=> (wb_cyc_o && wb_stb_o && $stable(wb_adr_o)))
        else $error("Wishbone request dropped or address changed before ack");

    a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        !wb_we_o)
        else $error("wb_we_o asserted on the fetch port");

    // Valid slots form a run starting at slot 0
    a_valid_contig: assert property (@(posedge clk) disable iff (!rst_n)
        ((instr_valid_o + 1'b1) & instr_valid_o) == '0)
        else $error("instr_valid_o is not contiguous from slot 0");

endmodule

bind ifu frontend_properties u_frontend_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_ack_i     (wb_ack_i),
    .instr_valid_o(instr_valid_o)
);

`default_nettype wire

//--- frontend.sv
`timescale 1ns/1ps
`default_nettype none

module frontend
    import frontend_pkg::*;
#(
    parameter int                    FTQ_DEPTH = 4,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC  = 32'h1c000000
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // Backend
    input  logic                                    backend_flush_i,
    input  logic [ADDR_WIDTH-1:0]                   backend_next_pc_i,
    input  logic                                    backend_commit_i,
    // Instruction buffer
    input  logic                                    instr_buffer_stall_i,
    output logic [FETCH_WIDTH-1:0]                  instr_valid_o,
    output logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] instr_o,
    output logic [ADDR_WIDTH-1:0]                   fetch_pc_o,
    // Wishbone master
    output logic                                    wb_cyc_o,
    output logic                                    wb_stb_o,
    output logic                                    wb_we_o,
    output logic [ADDR_WIDTH-1:0]                   wb_adr_o,
    input  logic [LINE_WIDTH-1:0]                   wb_dat_i,
    input  logic                                    wb_ack_i
);

    logic                       blk_valid;
    logic [ADDR_WIDTH-1:0]      blk_start_pc;
    logic [BLOCK_LEN_WIDTH-1:0] blk_length;
    logic                       ftq_full;

    logic                       req_valid;
    logic [ADDR_WIDTH-1:0]      req_start_pc;
    logic [BLOCK_LEN_WIDTH-1:0] req_length;
    logic                       req_accept;

    fetch_block_gen #(
        .RESET_PC(RESET_PC)
    ) u_fetch_block_gen (
        .clk              (clk),
        .rst_n            (rst_n),
        .backend_flush_i  (backend_flush_i),
        .backend_next_pc_i(backend_next_pc_i),
        .ftq_full_i       (ftq_full),
        .blk_valid_o      (blk_valid),
        .blk_start_pc_o   (blk_start_pc),
        .blk_length_o     (blk_length)
    );

    ftq #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_ftq (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (backend_flush_i),
        .blk_valid_i   (blk_valid),
        .blk_start_pc_i(blk_start_pc),
        .blk_length_i  (blk_length),
        .full_o        (ftq_full),
        .commit_i      (backend_commit_i),
        .req_valid_o   (req_valid),
        .req_start_pc_o(req_start_pc),
        .req_length_o  (req_length),
        .req_accept_i  (req_accept)
    );

    ifu u_ifu (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (backend_flush_i),
        .req_valid_i   (req_valid),
        .req_start_pc_i(req_start_pc),
        .req_length_i  (req_length),
        .req_accept_o  (req_accept),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .stall_i       (instr_buffer_stall_i),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .fetch_pc_o    (fetch_pc_o)
    );

endmodule

`default_nettype wire

//--- ifu.sv
`timescale 1ns/1ps
`default_nettype none

module ifu
    import frontend_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush_i,
    input  logic                                    req_valid_i,
    input  logic [ADDR_WIDTH-1:0]                   req_start_pc_i,
    input  logic [BLOCK_LEN_WIDTH-1:0]              req_length_i,
    output logic                                    req_accept_o,
    output logic                                    wb_cyc_o,
    output logic                                    wb_stb_o,
    output logic                                    wb_we_o,
    output logic [ADDR_WIDTH-1:0]                   wb_adr_o,
    input  logic [LINE_WIDTH-1:0]                   wb_dat_i,
    input  logic                                    wb_ack_i,
    input  logic                                    stall_i,
    output logic [FETCH_WIDTH-1:0]                  instr_valid_o,
    output logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] instr_o,
    output logic [ADDR_WIDTH-1:0]                   fetch_pc_o
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_LINE0 = 2'd1;
    localparam logic [1:0] S_LINE1 = 2'd2;
    localparam logic [1:0] S_OUT   = 2'd3;

    logic [1:0]                              state_q;
    logic                                    discard_q;
    logic [ADDR_WIDTH-1:0]                   start_pc_q;
    logic [BLOCK_LEN_WIDTH-1:0]              length_q;
    logic                                    need_second_q;
    cache_line_u                             line0_q;
    cache_line_u                             lo_line;
    cache_line_u                             hi_line;
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] merged;
    logic [FETCH_WIDTH-1:0]                  slot_mask;
    logic [FETCH_WIDTH-1:0]                  out_valid_q;
    logic                                    last_ack;

    assign wb_we_o = 1'b0;
    assign req_accept_o = (state_q == S_IDLE) && req_valid_i && !flush_i && !stall_i;
    assign last_ack = wb_cyc_o && wb_ack_i &&
                      ((state_q == S_LINE1) || ((state_q == S_LINE0) && !need_second_q));

    // Second line only contributes when the block runs past word 3
    always_comb begin
        logic [2:0] word_idx;
        lo_line.raw = (state_q == S_LINE1) ? line0_q.raw : wb_dat_i;
        hi_line.raw = wb_dat_i;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            word_idx = {1'b0, start_pc_q[LINE_OFFSET_W-1:WORD_OFFSET_W]} + 3'(i);
            if (word_idx[2]) begin
                merged[i] = hi_line.words[word_idx[1:0]];
            end else begin
                merged[i] = lo_line.words[word_idx[1:0]];
            end
            slot_mask[i] = (BLOCK_LEN_WIDTH'(i) < length_q);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= S_IDLE;
            wb_cyc_o    <= 1'b0;
            wb_stb_o    <= 1'b0;
            discard_q   <= 1'b0;
            out_valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_accept_o) begin
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        state_q  <= S_LINE0;
                    end
                end
                S_LINE0, S_LINE1: begin
                    if (!wb_cyc_o) begin
                        // Gap cycle between the two reads
                        if (flush_i) begin
                            state_q <= S_IDLE;
                        end else begin
                            wb_cyc_o <= 1'b1;
                            wb_stb_o <= 1'b1;
                        end
                    end else if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        if (discard_q || flush_i) begin
                            discard_q <= 1'b0;
                            state_q   <= S_IDLE;
                        end else if (last_ack) begin
                            out_valid_q <= slot_mask;
                            state_q     <= S_OUT;
                        end else begin
                            state_q <= S_LINE1;
                        end
                    end else if (flush_i) begin
                        // Open cycle must still see its ack
                        discard_q <= 1'b1;
                    end
                end
                default: begin
                    if (flush_i || !stall_i) begin
                        out_valid_q <= '0;
                        state_q     <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept_o) begin
            start_pc_q    <= req_start_pc_i;
            length_q      <= req_length_i;
            need_second_q <= ({1'b0, req_start_pc_i[LINE_OFFSET_W-1:WORD_OFFSET_W]}
                              + req_length_i) > 3'd4;
            wb_adr_o      <= {req_start_pc_i[ADDR_WIDTH-1:LINE_OFFSET_W],
                              {LINE_OFFSET_W{1'b0}}};
        end
        if ((state_q == S_LINE0) && wb_cyc_o && wb_ack_i) begin
            line0_q.raw <= wb_dat_i;
            wb_adr_o    <= wb_adr_o + ADDR_WIDTH'(LINE_BYTES);
        end
        if (last_ack) begin
            instr_o <= merged;
        end
    end

    // Held block stays registered, only the mask is hidden on stall
    assign instr_valid_o = stall_i ? '0 : out_valid_q;
    assign fetch_pc_o    = start_pc_q;

endmodule

`default_nettype wire

//--- ftq.sv
`timescale 1ns/1ps
`default_nettype none

module ftq
    import frontend_pkg::*;
#(
    parameter int FTQ_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush_i,
    input  logic                       blk_valid_i,
    input  logic [ADDR_WIDTH-1:0]      blk_start_pc_i,
    input  logic [BLOCK_LEN_WIDTH-1:0] blk_length_i,
    output logic                       full_o,
    input  logic                       commit_i,
    output logic                       req_valid_o,
    output logic [ADDR_WIDTH-1:0]      req_start_pc_o,
    output logic [BLOCK_LEN_WIDTH-1:0] req_length_o,
    input  logic                       req_accept_i
);

    localparam int PTR_WIDTH = (FTQ_DEPTH > 1) ? $clog2(FTQ_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FTQ_DEPTH + 1);

    logic [ADDR_WIDTH-1:0]      start_pc_mem [FTQ_DEPTH];
    logic [BLOCK_LEN_WIDTH-1:0] length_mem   [FTQ_DEPTH];

    logic [PTR_WIDTH-1:0] alloc_ptr;
    logic [PTR_WIDTH-1:0] issue_ptr;
    logic [CNT_WIDTH-1:0] occ_cnt;
    logic [CNT_WIDTH-1:0] issued_cnt;

    logic push;
    logic issue;
    logic retire;

    // Wrap at the depth, which need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(FTQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Issued entries still count toward full until committed
    assign full_o      = (occ_cnt == CNT_WIDTH'(FTQ_DEPTH));
    assign req_valid_o = (occ_cnt != issued_cnt);

    assign push   = blk_valid_i && !full_o && !flush_i;
    assign issue  = req_accept_i && req_valid_o && !flush_i;
    // Stray commit with nothing issued is dropped
    assign retire = commit_i && (issued_cnt != '0) && !flush_i;

    assign req_start_pc_o = start_pc_mem[issue_ptr];
    assign req_length_o   = length_mem[issue_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            start_pc_mem[alloc_ptr] <= blk_start_pc_i;
            length_mem[alloc_ptr]   <= blk_length_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_ptr  <= '0;
            issue_ptr  <= '0;
            occ_cnt    <= '0;
            issued_cnt <= '0;
        end else if (flush_i) begin
            alloc_ptr  <= '0;
            issue_ptr  <= '0;
            occ_cnt    <= '0;
            issued_cnt <= '0;
        end else begin
            if (push) begin
                alloc_ptr <= ptr_inc(alloc_ptr);
            end
            if (issue) begin
                issue_ptr <= ptr_inc(issue_ptr);
            end
            occ_cnt    <= occ_cnt + CNT_WIDTH'(push) - CNT_WIDTH'(retire);
            issued_cnt <= issued_cnt + CNT_WIDTH'(issue) - CNT_WIDTH'(retire);
        end
    end

endmodule

`default_nettype wire

//--- fetch_block_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_block_gen
    import frontend_pkg::*;
#(
    parameter logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c000000
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       backend_flush_i,
    input  logic [ADDR_WIDTH-1:0]      backend_next_pc_i,
    input  logic                       ftq_full_i,
    output logic                       blk_valid_o,
    output logic [ADDR_WIDTH-1:0]      blk_start_pc_o,
    output logic [BLOCK_LEN_WIDTH-1:0] blk_length_o
);

    logic [ADDR_WIDTH-1:0]    pc_q;
    logic [ADDR_WIDTH-1:0]    next_pc;
    logic [ADDR_WIDTH-1:0]    seq_pc;
    logic [PAGE_OFFSET_W-1:0] page_rem;
    logic                     page_cut;
    logic                     run_q;

    // Bytes left before the page end, zero meaning a whole page
    assign page_rem = PAGE_OFFSET_W'(0) - pc_q[PAGE_OFFSET_W-1:0];
    assign page_cut = (page_rem != '0) && (page_rem < PAGE_OFFSET_W'(FETCH_WIDTH * 4));

    // Short block ends exactly at the page boundary
    assign blk_length_o = page_cut ? BLOCK_LEN_WIDTH'(page_rem >> WORD_OFFSET_W)
                                   : BLOCK_LEN_WIDTH'(FETCH_WIDTH);
    assign blk_start_pc_o = pc_q;
    assign blk_valid_o = run_q && !ftq_full_i && !backend_flush_i;

    // Always predicts fall-through
    assign seq_pc = pc_q + {{(ADDR_WIDTH - BLOCK_LEN_WIDTH - 2){1'b0}}, blk_length_o, 2'b00};

    always_comb begin
        if (backend_flush_i) begin
            next_pc = backend_next_pc_i;
        end else if (ftq_full_i || !run_q) begin
            next_pc = pc_q;
        end else begin
            next_pc = seq_pc;
        end
    end

    // First push waits one cycle after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            pc_q  <= RESET_PC;
        end else begin
            run_q <= 1'b1;
            pc_q  <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // Fetch address and block geometry
    localparam int ADDR_WIDTH = 32;
    localparam int FETCH_WIDTH = 4;
    localparam int BLOCK_LEN_WIDTH = 3;
    localparam int INSTR_WIDTH = 32;

    // 4 KB pages bound every fetch block
    localparam int PAGE_OFFSET_W = 12;

    // Byte offset of a word inside its line
    localparam int WORD_OFFSET_W = 2;

    // One cache line is a single Wishbone data beat
    localparam int LINE_WIDTH = 128;
    localparam int LINE_WORDS = LINE_WIDTH / INSTR_WIDTH;
    localparam int LINE_BYTES = LINE_WIDTH / 8;
    localparam int LINE_OFFSET_W = $clog2(LINE_BYTES);

    // Raw bus beat, or the instruction words selected by address bits 3:2
    typedef union packed {
        logic [LINE_WIDTH-1:0]                   raw;
        logic [LINE_WORDS-1:0][INSTR_WIDTH-1:0]  words;
    } cache_line_u;

endpackage

`default_nettype wire
